// File: hw/core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// ------------------------------------------------------------
// datapath and memory sizing
// ------------------------------------------------------------

// data and address width of the core.
`define CORE_XLEN 32

// depth of the shared word memory.
`define CORE_MEM_WORDS 1024

// first pc after reset.
`define CORE_RESET_PC 32'h0000_0000

// width of the next-pc source select coming from execute.
`define CORE_DNPC_SEL_W 3

`endif

// File: hw/core_pkg.sv
`include "core_settings.svh"

package core_pkg;

    // ------------------------------------------------------------
    // next-pc source and access size encodings
    // ------------------------------------------------------------

    // codes 6 and 7 are unused and send the pc to address 0.
    typedef enum logic [`CORE_DNPC_SEL_W-1:0] {
        sel_snpc   = 3'd0,
        sel_pc_imm = 3'd1,
        sel_alu_jr = 3'd2,
        sel_branch = 3'd3,
        sel_mtvec  = 3'd4,
        sel_mepc   = 3'd5
    } dnpc_sel_e;

    typedef enum logic [1:0] {
        ls_byte = 2'd0,
        ls_half = 2'd1,
        ls_word = 2'd2
    } ls_size_e;

    // ------------------------------------------------------------
    // response payloads
    // ------------------------------------------------------------

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [`CORE_XLEN-1:0] inst;
    } fetch_rsp_t;

    // rdata is zero when store_ack is set.
    typedef struct packed {
        logic [`CORE_XLEN-1:0] rdata;
        logic                  store_ack;
    } load_rsp_t;

endpackage

// File: hw/mem_bus_if.sv
`timescale 1ns/1ps
`include "core_settings.svh"

interface mem_bus_if;

    logic                      req_valid;
    logic                      req_ready;
    logic [`CORE_XLEN-1:0]     addr;
    logic                      we;
    logic [`CORE_XLEN-1:0]     wdata;
    logic [`CORE_XLEN/8-1:0]   wstrb;
    logic                      rsp_valid;
    logic [`CORE_XLEN-1:0]     rdata;

    // one rsp_valid pulse follows every accepted request, stores included.
    modport master (
        output req_valid, addr, we, wdata, wstrb,
        input  req_ready, rsp_valid, rdata
    );

    modport slave (
        input  req_valid, addr, we, wdata, wstrb,
        output req_ready, rsp_valid, rdata
    );

endinterface

// File: hw/resp_buffer.sv
`timescale 1ns/1ps

module resp_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,

    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // a full entry can be replaced in the same cycle it drains.
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            full <= 1'b0;
        end else if (in_valid && in_ready) begin
            full <= 1'b1;
        end else if (out_ready) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

// File: hw/sram.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module sram (
    input logic      clk,
    input logic      rst,
    mem_bus_if.slave bus
);

    localparam int IDX_W = $clog2(`CORE_MEM_WORDS);

    logic [`CORE_XLEN-1:0] mem [`CORE_MEM_WORDS];
    logic [`CORE_XLEN-1:0] rdata_q;
    logic                  pending;
    logic [IDX_W-1:0]      idx;
    logic                  accept;

    // the two low address bits pick byte lanes and do not take part here.
    assign idx    = bus.addr[IDX_W+1:2];
    assign accept = bus.req_valid && bus.req_ready;

    assign bus.req_ready = !pending;
    assign bus.rsp_valid = pending;
    assign bus.rdata     = rdata_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= 1'b0;
        end else begin
            pending <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= mem[idx];
            if (bus.we) begin
                for (int i = 0; i < `CORE_XLEN/8; i++) begin
                    if (bus.wstrb[i]) begin
                        mem[idx][i*8 +: 8] <= bus.wdata[i*8 +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: hw/mem_arbiter.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module mem_arbiter (
    input logic       clk,
    input logic       rst,
    mem_bus_if.slave  ifu_bus,
    mem_bus_if.slave  lsu_bus,
    mem_bus_if.master mem_bus
);

    logic busy;
    logic owner_lsu;
    logic sel_lsu;

    // ------------------------------------------------------------
    // request path
    // ------------------------------------------------------------

    // the load/store side wins a tie; a held grant keeps the owner.
    assign sel_lsu = busy ? owner_lsu : lsu_bus.req_valid;

    assign mem_bus.req_valid = !busy && (ifu_bus.req_valid || lsu_bus.req_valid);
    assign mem_bus.addr      = sel_lsu ? lsu_bus.addr  : ifu_bus.addr;
    assign mem_bus.we        = sel_lsu ? lsu_bus.we    : ifu_bus.we;
    assign mem_bus.wdata     = sel_lsu ? lsu_bus.wdata : ifu_bus.wdata;
    assign mem_bus.wstrb     = sel_lsu ? lsu_bus.wstrb : ifu_bus.wstrb;

    assign lsu_bus.req_ready = !busy && mem_bus.req_ready;
    assign ifu_bus.req_ready = !busy && !lsu_bus.req_valid && mem_bus.req_ready;

    // ------------------------------------------------------------
    // response path
    // ------------------------------------------------------------

    assign lsu_bus.rsp_valid = busy && owner_lsu && mem_bus.rsp_valid;
    assign ifu_bus.rsp_valid = busy && !owner_lsu && mem_bus.rsp_valid;
    assign lsu_bus.rdata     = owner_lsu ? mem_bus.rdata : '0;
    assign ifu_bus.rdata     = owner_lsu ? '0 : mem_bus.rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            owner_lsu <= 1'b0;
        end else if (mem_bus.req_valid && mem_bus.req_ready) begin
            busy      <= 1'b1;
            owner_lsu <= lsu_bus.req_valid;
        end else if (mem_bus.rsp_valid) begin
            busy      <= 1'b0;
        end
    end

endmodule

// File: hw/fetch_unit.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module fetch_unit import core_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_en,

    input  logic [`CORE_DNPC_SEL_W-1:0] dnpc_sel,
    input  logic [`CORE_XLEN-1:0]       pc_imm,
    input  logic [`CORE_XLEN-1:0]       alu_result,
    input  logic [`CORE_XLEN-1:0]       mtvec,
    input  logic [`CORE_XLEN-1:0]       mepc,

    mem_bus_if.master                   bus,

    output logic                        rsp_valid,
    output fetch_rsp_t                  rsp,
    input  logic                        buf_ready,
    input  logic                        inst_taken
);

    typedef enum logic [1:0] {
        st_fetch,
        st_wait_rsp,
        st_wait_taken
    } state_e;

    state_e                state;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] snpc;
    logic [`CORE_XLEN-1:0] dnpc;
    logic                  req_hold;

    assign snpc = pc + `CORE_XLEN'd4;

    // ------------------------------------------------------------
    // next-pc selection
    // ------------------------------------------------------------

    always_comb begin
        case (dnpc_sel)
            sel_snpc:   dnpc = snpc;
            sel_pc_imm: dnpc = pc_imm;
            sel_alu_jr: dnpc = alu_result & ~`CORE_XLEN'd1;
            sel_branch: dnpc = alu_result[0] ? pc_imm : snpc;
            sel_mtvec:  dnpc = mtvec;
            sel_mepc:   dnpc = mepc;
            default:    dnpc = '0;
        endcase
    end

    // once raised, the request stays up even if fetch_en drops.
    assign bus.req_valid = (state == st_fetch) && buf_ready && (fetch_en || req_hold);
    assign bus.addr      = pc;
    assign bus.we        = 1'b0;
    assign bus.wdata     = '0;
    assign bus.wstrb     = '0;

    assign rsp_valid = (state == st_wait_rsp) && bus.rsp_valid;
    assign rsp.pc    = pc;
    assign rsp.inst  = bus.rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_fetch;
            pc       <= `CORE_RESET_PC;
            req_hold <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    req_hold <= bus.req_valid && !bus.req_ready;
                    if (bus.req_valid && bus.req_ready) begin
                        state <= st_wait_rsp;
                    end
                end
                st_wait_rsp: begin
                    if (bus.rsp_valid) begin
                        state <= st_wait_taken;
                    end
                end
                default: begin
                    // redirect operands are sampled with the transfer.
                    if (inst_taken) begin
                        pc    <= dnpc;
                        state <= st_fetch;
                    end
                end
            endcase
        end
    end

endmodule

// File: hw/load_store_unit.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module load_store_unit import core_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,

    input  logic                  req_valid,
    output logic                  req_ready,
    input  logic [`CORE_XLEN-1:0] req_addr,
    input  logic                  req_we,
    input  logic [1:0]            req_size,
    input  logic                  req_unsigned,
    input  logic [`CORE_XLEN-1:0] req_wdata,

    mem_bus_if.master             bus,

    output logic                  rsp_valid,
    output load_rsp_t             rsp,
    input  logic                  buf_ready
);

    typedef enum logic {
        st_idle,
        st_wait_rsp
    } state_e;

    state_e                  state;
    ls_size_e                size_in;
    ls_size_e                size_q;
    logic                    unsigned_q;
    logic [1:0]              off_q;
    logic                    we_q;
    logic [`CORE_XLEN-1:0]   shifted;
    logic [`CORE_XLEN-1:0]   load_data;

    assign size_in = ls_size_e'(req_size);

    // ------------------------------------------------------------
    // request side
    // ------------------------------------------------------------

    // the external request goes straight onto the bus in the same cycle.
    assign bus.req_valid = (state == st_idle) && req_valid && buf_ready;
    assign req_ready     = (state == st_idle) && buf_ready && bus.req_ready;
    assign bus.addr      = req_addr;
    assign bus.we        = req_we;

    always_comb begin
        case (size_in)
            ls_byte: begin
                bus.wdata = {4{req_wdata[7:0]}};
                bus.wstrb = 4'b0001 << req_addr[1:0];
            end
            ls_half: begin
                bus.wdata = {2{req_wdata[15:0]}};
                bus.wstrb = req_addr[1] ? 4'b1100 : 4'b0011;
            end
            default: begin
                bus.wdata = req_wdata;
                bus.wstrb = 4'b1111;
            end
        endcase
    end

    // ------------------------------------------------------------
    // response side
    // ------------------------------------------------------------

    assign shifted = bus.rdata >> {off_q, 3'b000};

    always_comb begin
        case (size_q)
            ls_byte: load_data = unsigned_q ? {{(`CORE_XLEN-8){1'b0}}, shifted[7:0]}
                                            : {{(`CORE_XLEN-8){shifted[7]}}, shifted[7:0]};
            ls_half: load_data = unsigned_q ? {{(`CORE_XLEN-16){1'b0}}, shifted[15:0]}
                                            : {{(`CORE_XLEN-16){shifted[15]}}, shifted[15:0]};
            default: load_data = shifted;
        endcase
    end

    assign rsp_valid     = (state == st_wait_rsp) && bus.rsp_valid;
    assign rsp.rdata     = we_q ? '0 : load_data;
    assign rsp.store_ack = we_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else if (state == st_idle) begin
            if (req_valid && req_ready) begin
                state <= st_wait_rsp;
            end
        end else if (bus.rsp_valid) begin
            state <= st_idle;
        end
    end

    // access attributes kept for shaping the response.
    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            size_q     <= size_in;
            unsigned_q <= req_unsigned;
            off_q      <= req_addr[1:0];
            we_q       <= req_we;
        end
    end

endmodule

// File: hw/core_mem_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_mem_top import core_pkg::*; (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fetch_en,
    input  logic [`CORE_DNPC_SEL_W-1:0] dnpc_sel,
    input  logic [`CORE_XLEN-1:0]       pc_imm,
    input  logic [`CORE_XLEN-1:0]       alu_result,
    input  logic [`CORE_XLEN-1:0]       mtvec,
    input  logic [`CORE_XLEN-1:0]       mepc,

    output logic                        inst_valid,
    input  logic                        inst_ready,
    output logic [`CORE_XLEN-1:0]       inst_pc,
    output logic [`CORE_XLEN-1:0]       inst,

    input  logic                        ls_req_valid,
    output logic                        ls_req_ready,
    input  logic [`CORE_XLEN-1:0]       ls_addr,
    input  logic                        ls_we,
    input  logic [1:0]                  ls_size,
    input  logic                        ls_unsigned,
    input  logic [`CORE_XLEN-1:0]       ls_wdata,

    output logic                        ls_rsp_valid,
    input  logic                        ls_rsp_ready,
    output logic [`CORE_XLEN-1:0]       ls_rdata,
    output logic                        ls_store_ack
);

    mem_bus_if ifu_bus ();
    mem_bus_if lsu_bus ();
    mem_bus_if mem_bus ();

    logic       fetch_valid;
    logic       fetch_ready;
    fetch_rsp_t fetch_rsp;
    fetch_rsp_t inst_rsp;
    logic       load_valid;
    logic       load_ready;
    load_rsp_t  load_rsp;
    load_rsp_t  ls_rsp;

    fetch_unit u_fetch_unit (
        .clk(clk), .rst(rst), .fetch_en(fetch_en),
        .dnpc_sel(dnpc_sel), .pc_imm(pc_imm), .alu_result(alu_result),
        .mtvec(mtvec), .mepc(mepc), .bus(ifu_bus),
        .rsp_valid(fetch_valid), .rsp(fetch_rsp), .buf_ready(fetch_ready),
        .inst_taken(inst_valid && inst_ready)
    );

    resp_buffer #(.payload_t(fetch_rsp_t)) u_inst_buffer (
        .clk(clk), .rst(rst),
        .in_valid(fetch_valid), .in_ready(fetch_ready), .in_data(fetch_rsp),
        .out_valid(inst_valid), .out_ready(inst_ready), .out_data(inst_rsp)
    );

    load_store_unit u_load_store_unit (
        .clk(clk), .rst(rst),
        .req_valid(ls_req_valid), .req_ready(ls_req_ready), .req_addr(ls_addr),
        .req_we(ls_we), .req_size(ls_size), .req_unsigned(ls_unsigned),
        .req_wdata(ls_wdata), .bus(lsu_bus),
        .rsp_valid(load_valid), .rsp(load_rsp), .buf_ready(load_ready)
    );

    resp_buffer #(.payload_t(load_rsp_t)) u_ls_buffer (
        .clk(clk), .rst(rst),
        .in_valid(load_valid), .in_ready(load_ready), .in_data(load_rsp),
        .out_valid(ls_rsp_valid), .out_ready(ls_rsp_ready), .out_data(ls_rsp)
    );

    mem_arbiter u_mem_arbiter (
        .clk(clk), .rst(rst),
        .ifu_bus(ifu_bus), .lsu_bus(lsu_bus), .mem_bus(mem_bus)
    );

    sram u_sram (.clk(clk), .rst(rst), .bus(mem_bus));

    assign inst_pc      = inst_rsp.pc;
    assign inst         = inst_rsp.inst;
    assign ls_rdata     = ls_rsp.rdata;
    assign ls_store_ack = ls_rsp.store_ack;

endmodule

// File: verif/tb_core_mem_top.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_core_mem_top import core_pkg::*; ();

    localparam int          WAIT_LIMIT = 200;
    localparam int          PROG_WORDS = 64;
    localparam int          DATA_WORDS = 16;
    localparam int          IDX_W      = $clog2(`CORE_MEM_WORDS);
    localparam logic [31:0] DATA_BASE  = 32'h0000_0800;
    localparam logic [31:0] SEED       = 32'hc665c370;

    logic                        clk;
    logic                        rst;
    logic                        fetch_en;
    logic [`CORE_DNPC_SEL_W-1:0] dnpc_sel;
    logic [`CORE_XLEN-1:0]       pc_imm;
    logic [`CORE_XLEN-1:0]       alu_result;
    logic [`CORE_XLEN-1:0]       mtvec;
    logic [`CORE_XLEN-1:0]       mepc;
    logic                        inst_valid;
    logic                        inst_ready;
    logic [`CORE_XLEN-1:0]       inst_pc;
    logic [`CORE_XLEN-1:0]       inst;
    logic                        ls_req_valid;
    logic                        ls_req_ready;
    logic [`CORE_XLEN-1:0]       ls_addr;
    logic                        ls_we;
    logic [1:0]                  ls_size;
    logic                        ls_unsigned;
    logic [`CORE_XLEN-1:0]       ls_wdata;
    logic                        ls_rsp_valid;
    logic                        ls_rsp_ready;
    logic [`CORE_XLEN-1:0]       ls_rdata;
    logic                        ls_store_ack;

    // expected memory contents and the pc of the next instruction.
    logic [`CORE_XLEN-1:0] mem_model [`CORE_MEM_WORDS];
    logic [`CORE_XLEN-1:0] exp_pc;

    core_mem_top u_core_mem_top (.*);

    always #50 clk = ~clk;

    // ------------------------------------------------------------
    // error reporting and compare tasks
    // ------------------------------------------------------------

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [`CORE_XLEN-1:0] got,
                                   input logic [`CORE_XLEN-1:0] exp);
        fail_run($sformatf("mismatch at %0d ns: %s is %h, expected %h",
                           $time, name, got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) report_mismatch(name, 32'(got), 32'(exp));
    endtask

    task automatic check_fetch(input fetch_rsp_t got, input fetch_rsp_t exp);
        if (got.pc !== exp.pc) report_mismatch("inst_pc", got.pc, exp.pc);
        if (got.inst !== exp.inst) report_mismatch("inst", got.inst, exp.inst);
    endtask

    task automatic check_load(input load_rsp_t got, input load_rsp_t exp);
        if (got.rdata !== exp.rdata) report_mismatch("ls_rdata", got.rdata, exp.rdata);
        if (got.store_ack !== exp.store_ack) begin
            report_mismatch("ls_store_ack", 32'(got.store_ack), 32'(exp.store_ack));
        end
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    function automatic logic [31:0] predict_pc(input logic [31:0] pc, input logic [2:0] sel,
                                               input logic [31:0] imm, input logic [31:0] alu,
                                               input logic [31:0] tvec, input logic [31:0] epc);
        case (sel)
            sel_snpc:   return pc + 32'd4;
            sel_pc_imm: return imm;
            sel_alu_jr: return {alu[31:1], 1'b0};
            sel_branch: return alu[0] ? imm : pc + 32'd4;
            sel_mtvec:  return tvec;
            sel_mepc:   return epc;
            default:    return 32'd0;
        endcase
    endfunction

    function automatic logic [31:0] expect_load(input logic [31:0] word, input logic [1:0] lane,
                                                input ls_size_e size, input logic uns);
        logic [7:0]  b;
        logic [15:0] h;
        case (size)
            ls_byte: begin
                b = word[lane*8 +: 8];
                return uns ? {24'h0, b} : {{24{b[7]}}, b};
            end
            ls_half: begin
                h = word[lane*8 +: 16];
                return uns ? {16'h0, h} : {{16{h[15]}}, h};
            end
            default: return word;
        endcase
    endfunction

    task automatic model_store(input logic [31:0] addr, input ls_size_e size,
                               input logic [31:0] data);
        int idx;
        idx = addr[IDX_W+1:2];
        case (size)
            ls_byte: mem_model[idx][addr[1:0]*8 +: 8] = data[7:0];
            ls_half: mem_model[idx][addr[1:0]*8 +: 16] = data[15:0];
            default: mem_model[idx] = data;
        endcase
    endtask

    // aligned jump target inside the program, leaving room for one more word.
    function automatic logic [31:0] rand_target();
        return 32'($urandom_range(PROG_WORDS - 2)) << 2;
    endfunction

    function automatic logic [1:0] pick_lane(input ls_size_e size);
        case (size)
            ls_byte: return 2'($urandom_range(3));
            ls_half: return {1'($urandom_range(1)), 1'b0};
            default: return 2'b00;
        endcase
    endfunction

    // ------------------------------------------------------------
    // drive tasks
    // ------------------------------------------------------------

    task automatic ls_send(input logic [31:0] addr, input logic we, input ls_size_e size,
                           input logic uns, input logic [31:0] data);
        int waited;
        waited       = 0;
        ls_req_valid = 1'b1;
        ls_addr      = addr;
        ls_we        = we;
        ls_size      = size;
        ls_unsigned  = uns;
        ls_wdata     = data;
        @(negedge clk);
        while (!ls_req_ready) begin
            waited++;
            if (waited > WAIT_LIMIT) fail_run("timeout: ls_req_ready never rose for a request");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        ls_req_valid = 1'b0;
    endtask

    task automatic ls_receive(input int hold, output load_rsp_t got);
        load_rsp_t now_rsp;
        int        waited;
        waited = 0;
        @(negedge clk);
        while (!ls_rsp_valid) begin
            waited++;
            if (waited > WAIT_LIMIT) fail_run("timeout: no response arrived on ls_rsp_valid");
            @(negedge clk);
        end
        got = {ls_rdata, ls_store_ack};
        // the buffer has to keep the response while ready stays low.
        repeat (hold) begin
            @(negedge clk);
            now_rsp = {ls_rdata, ls_store_ack};
            check_flag("ls_rsp_valid", ls_rsp_valid, 1'b1);
            check_load(now_rsp, got);
        end
        @(posedge clk);
        #1;
        ls_rsp_ready = 1'b1;
        @(posedge clk);
        #1;
        ls_rsp_ready = 1'b0;
    endtask

    task automatic ls_store(input logic [31:0] addr, input ls_size_e size,
                            input logic [31:0] data, input int hold);
        load_rsp_t got;
        load_rsp_t exp;
        exp.rdata     = '0;
        exp.store_ack = 1'b1;
        ls_send(addr, 1'b1, size, 1'b0, data);
        ls_receive(hold, got);
        check_load(got, exp);
        model_store(addr, size, data);
    endtask

    task automatic ls_load(input logic [31:0] addr, input ls_size_e size, input logic uns,
                           input int hold);
        load_rsp_t got;
        load_rsp_t exp;
        exp.rdata     = expect_load(mem_model[addr[IDX_W+1:2]], addr[1:0], size, uns);
        exp.store_ack = 1'b0;
        ls_send(addr, 1'b0, size, uns, $urandom);
        ls_receive(hold, got);
        check_load(got, exp);
    endtask

    task automatic take_inst(input int hold, input logic [`CORE_DNPC_SEL_W-1:0] sel,
                             input logic [31:0] imm, input logic [31:0] alu,
                             input logic [31:0] tvec, input logic [31:0] epc);
        fetch_rsp_t exp;
        fetch_rsp_t now_rsp;
        int         waited;
        waited   = 0;
        exp.pc   = exp_pc;
        exp.inst = mem_model[exp_pc[IDX_W+1:2]];
        @(negedge clk);
        while (!inst_valid) begin
            waited++;
            if (waited > WAIT_LIMIT) fail_run("timeout: no instruction arrived on inst_valid");
            @(negedge clk);
        end
        now_rsp = {inst_pc, inst};
        check_fetch(now_rsp, exp);
        repeat (hold) begin
            @(negedge clk);
            now_rsp = {inst_pc, inst};
            check_flag("inst_valid", inst_valid, 1'b1);
            check_fetch(now_rsp, exp);
        end
        @(posedge clk);
        #1;
        inst_ready = 1'b1;
        dnpc_sel   = sel;
        pc_imm     = imm;
        alu_result = alu;
        mtvec      = tvec;
        mepc       = epc;
        @(posedge clk);
        #1;
        inst_ready = 1'b0;
        exp_pc     = predict_pc(exp_pc, sel, imm, alu, tvec, epc);
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------

    task automatic test_reset_state();
        @(negedge clk);
        check_flag("inst_valid", inst_valid, 1'b0);
        check_flag("ls_rsp_valid", ls_rsp_valid, 1'b0);
        check_flag("ls_req_ready", ls_req_ready, 1'b1);
        @(posedge clk);
        #1;
    endtask

    // fetch stays off here so no instruction is read before it is written.
    task automatic load_program();
        for (int i = 0; i < PROG_WORDS; i++) begin
            ls_store(32'(i) * 4, ls_word, $urandom, 0);
        end
        for (int i = 0; i < DATA_WORDS; i++) begin
            ls_store(DATA_BASE + 32'(i) * 4, ls_word, $urandom, 0);
        end
    endtask

    task automatic test_sequential_fetch();
        fetch_en = 1'b1;
        exp_pc   = `CORE_RESET_PC;
        repeat (17) begin
            take_inst(0, sel_snpc, $urandom, $urandom, $urandom, $urandom);
        end
    endtask

    task automatic test_redirects();
        take_inst(0, sel_pc_imm, rand_target(), $urandom, $urandom, $urandom);
        take_inst(0, sel_branch, rand_target(), $urandom & ~32'd1, $urandom, $urandom);
        take_inst(0, sel_alu_jr, $urandom, rand_target() | 32'd1, $urandom, $urandom);
        take_inst(0, sel_branch, rand_target(), $urandom | 32'd1, $urandom, $urandom);
        take_inst(0, sel_mtvec, $urandom, $urandom, rand_target(), $urandom);
        take_inst(0, sel_mepc, $urandom, $urandom, $urandom, rand_target());
        take_inst(0, 3'd6, rand_target(), $urandom, rand_target(), rand_target());
        take_inst(0, sel_mepc, $urandom, $urandom, $urandom, rand_target());
        take_inst(0, 3'd7, rand_target(), $urandom, rand_target(), rand_target());
        take_inst(0, sel_snpc, $urandom, $urandom, $urandom, $urandom);
    endtask

    task automatic test_load_store_sizes();
        logic [31:0] base;
        ls_size_e    st_size;
        ls_size_e    ld_size;
        for (int i = 0; i < 36; i++) begin
            base    = DATA_BASE + 32'($urandom_range(DATA_WORDS - 1)) * 4;
            st_size = ls_size_e'($urandom_range(2));
            ld_size = ls_size_e'(i % 3);
            ls_store(base + pick_lane(st_size), st_size, $urandom, 0);
            ls_load(base + pick_lane(ld_size), ld_size, 1'((i / 3) % 2), 0);
        end
    endtask

    task automatic test_contention();
        fork
            begin : fetch_side
                for (int i = 0; i < 30; i++) begin
                    if (exp_pc >= (PROG_WORDS - 2) * 4 || $urandom_range(5) == 0) begin
                        take_inst($urandom_range(3), sel_pc_imm, rand_target(),
                                  $urandom, $urandom, $urandom);
                    end else begin
                        take_inst($urandom_range(3), sel_snpc, $urandom,
                                  $urandom, $urandom, $urandom);
                    end
                end
            end
            begin : data_side
                logic [31:0] addr;
                ls_size_e    size;
                for (int i = 0; i < 30; i++) begin
                    size = ls_size_e'($urandom_range(2));
                    addr = DATA_BASE + 32'($urandom_range(DATA_WORDS - 1)) * 4 + pick_lane(size);
                    if ($urandom_range(3) == 0) begin
                        ls_store(addr, size, $urandom, $urandom_range(3));
                    end else begin
                        ls_load(addr, size, 1'($urandom_range(1)), $urandom_range(3));
                    end
                end
            end
        join
    endtask

    initial begin
        void'($urandom(SEED));
        clk          = 1'b0;
        rst          = 1'b1;
        fetch_en     = 1'b0;
        dnpc_sel     = sel_snpc;
        pc_imm       = '0;
        alu_result   = '0;
        mtvec        = '0;
        mepc         = '0;
        inst_ready   = 1'b0;
        ls_req_valid = 1'b0;
        ls_addr      = '0;
        ls_we        = 1'b0;
        ls_size      = ls_word;
        ls_unsigned  = 1'b0;
        ls_wdata     = '0;
        ls_rsp_ready = 1'b0;
        exp_pc       = `CORE_RESET_PC;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;

        test_reset_state();
        load_program();
        test_sequential_fetch();
        test_redirects();
        test_load_store_sizes();
        test_contention();

        $display("TEST PASS");
        $finish;
    end

endmodule

// File: project.f
+incdir+hw
hw/core_pkg.sv
hw/mem_bus_if.sv
hw/resp_buffer.sv
hw/sram.sv
hw/mem_arbiter.sv
hw/fetch_unit.sv
hw/load_store_unit.sv
hw/core_mem_top.sv
verif/tb_core_mem_top.sv
